//--- source/z80_bus_pkg.sv
package z80_bus_pkg;

    ////////////////////////////////////////
    // Raw Z80 expansion bus
    ////////////////////////////////////////

    // Pins as seen at the FPGA, all async to sysclk
    typedef struct packed {
        logic [15:0] addr;      // CPU address
        logic [7:0]  data;      // Data bus, input side only
        logic        rd_n;      // Read strobe
        logic        wr_n;      // Write strobe
        logic        mreq_n;    // Memory request
        logic        iorq_n;    // I/O request
        logic        m1_n;      // Opcode fetch / int ack marker
    } z80_bus_s;

    ////////////////////////////////////////
    // Synchronized I/O cycle
    ////////////////////////////////////////

    // Handed from the sampler to the register block
    typedef struct packed {
        logic [7:0] port;       // Low address byte
        logic [7:0] data;       // Write data
        logic       wr_pulse;   // Single sysclk strobe per I/O write
        logic       rd_active;  // Held for the whole I/O read
    } io_req_s;

    ////////////////////////////////////////
    // I/O map
    ////////////////////////////////////////

    // Bank registers live at F0h..F3h
    localparam logic [7:0] bank_port_base = 8'hF0;

    // Port bits that pick one of the four banks
    localparam int bank_sel_bits = 2;

    // Z80 can still do I/O while in a wait
    // state, the sampler does not care

endpackage

//--- source/memmap_pkg.sv
package memmap_pkg;

    ////////////////////////////////////////
    // Bank register layout
    ////////////////////////////////////////

    // Mapper view of one bank byte
    typedef struct packed {
        logic       readonly;   // Blocks memory writes to the quarter
        logic       reserved;   // Stored and read back, no effect
        logic [5:0] page;       // 16 KB page number
    } bank_fields_s;

    // Same byte, raw over I/O or split for the mapper
    typedef union packed {
        logic [7:0]   raw;
        bank_fields_s fields;
    } bank_reg_u;

    // One register per 16 KB CPU quarter, index = addr[15:14]
    typedef bank_reg_u [3:0] bank_set_t;

    ////////////////////////////////////////
    // Memory side outputs
    ////////////////////////////////////////

    typedef struct packed {
        logic [4:0] ba;         // Upper physical address bits
        logic       rom_ce_n;   // Flash
        logic       cart_ce_n;  // Cartridge slot
        logic       ram_ce_n;   // SRAM
    } mem_sel_s;

    ////////////////////////////////////////
    // Page regions
    ////////////////////////////////////////

    // Decided by page[5:4]
    localparam logic [1:0] region_rom  = 2'b00;  // Pages 0..15
    localparam logic [1:0] region_cart = 2'b01;  // Pages 16..31
    localparam logic       region_ram  = 1'b1;   // page[5] set, pages 32..63

    ////////////////////////////////////////
    // Power-up map
    ////////////////////////////////////////

    // Quarter 3 down to quarter 0
    localparam bank_set_t bank_reset_value = {
        8'h93,      // Cartridge page 19, readonly
        8'h22,      // RAM page 34
        8'h21,      // RAM page 33
        8'h80       // ROM page 0, readonly
    };

endpackage

//--- source/z80_clock_reset.sv
`timescale 1ns/1ps

module z80_clock_reset #(
    parameter int reset_bits = 22           // 2^22 sysclk, roughly 146 ms
) (
    input  logic sysclk,
    input  logic rst_n,
    output logic z80_reset_n,
    output logic phi
);

    ////////////////////////////////////////
    // Phase clock
    ////////////////////////////////////////

    logic [1:0] phi_div;                    // Divide by 4

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            phi_div <= 2'b00;
        end else begin
            phi_div <= phi_div + 2'b01;     // Free running, ignores Z80 reset
        end
    end

    assign phi = phi_div[1];                // Low for 2, high for 2

    ////////////////////////////////////////
    // Reset stretcher
    ////////////////////////////////////////

    // One extra bit, the MSB is the done flag
    logic [reset_bits:0] rst_cnt;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            rst_cnt <= '0;                  // Restart on every board reset
        end else if (!rst_cnt[reset_bits]) begin
            rst_cnt <= rst_cnt + 1'b1;
        end
    end

    // Counter parks once the MSB sets
    assign z80_reset_n = rst_cnt[reset_bits];   // Release after 2^reset_bits edges

endmodule

//--- source/z80_bus_sampler.sv
`timescale 1ns/1ps

module z80_bus_sampler
    import z80_bus_pkg::*;
(
    input  logic     sysclk,
    input  logic     rst_n,
    input  z80_bus_s bus,
    output io_req_s  io_req
);

    ////////////////////////////////////////
    // Strobe synchronizer
    ////////////////////////////////////////

    // Bit order {iorq_n, rd_n, wr_n, m1_n}
    logic [3:0] strb_s1;
    logic [3:0] strb_s2;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            strb_s1 <= 4'hF;                // All strobes idle
            strb_s2 <= 4'hF;
        end else begin
            strb_s1 <= {bus.iorq_n, bus.rd_n, bus.wr_n, bus.m1_n};
            strb_s2 <= strb_s1;
        end
    end

    // Port and data follow the same two stages
    logic [7:0] port_s1, port_s2;
    logic [7:0] data_s1, data_s2;

    always_ff @(posedge sysclk) begin
        port_s1 <= bus.addr[7:0];           // I/O port is the low byte
        port_s2 <= port_s1;
        data_s1 <= bus.data;
        data_s2 <= data_s1;
    end

    ////////////////////////////////////////
    // I/O cycle decode
    ////////////////////////////////////////

    logic iorq_s, rd_s, wr_s, m1_s;
    logic io_wr;                            // Synchronized I/O write level
    logic io_rd;                            // Synchronized I/O read level
    logic io_wr_d;                          // Previous io_wr for edge detect

    assign iorq_s = strb_s2[3];
    assign rd_s   = strb_s2[2];
    assign wr_s   = strb_s2[1];
    assign m1_s   = strb_s2[0];

    // Strobes active low; m1 low with iorq low is int ack
    assign io_wr = !iorq_s && !wr_s && m1_s;
    assign io_rd = !iorq_s && !rd_s && m1_s;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            io_wr_d          <= 1'b0;
            io_req           <= '0;
        end else begin
            io_wr_d          <= io_wr;
            io_req.port      <= port_s2;            // Payload registered alongside the strobes
            io_req.data      <= data_s2;
            io_req.wr_pulse  <= io_wr && !io_wr_d;  // Rising edge only
            io_req.rd_active <= io_rd;              // Level while read lasts
        end
    end

endmodule

//--- source/bank_regs.sv
`timescale 1ns/1ps

module bank_regs
    import z80_bus_pkg::*;
    import memmap_pkg::*;
(
    input  logic       sysclk,
    input  logic       rst_n,
    input  io_req_s    io_req,
    output bank_set_t  bank_set,
    output logic [7:0] d_out,
    output logic       d_oe
);

    ////////////////////////////////////////
    // Port decode
    ////////////////////////////////////////

    logic                     port_hit;     // F0h..F3h
    logic [bank_sel_bits-1:0] port_sel;     // Which bank

    assign port_hit = (io_req.port[7:bank_sel_bits] ==
                       bank_port_base[7:bank_sel_bits]);
    assign port_sel = io_req.port[bank_sel_bits-1:0];

    ////////////////////////////////////////
    // Bank registers
    ////////////////////////////////////////

    bank_set_t bank_r;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            bank_r <= bank_reset_value;     // ROM, RAM, RAM, cart
        end else if (io_req.wr_pulse && port_hit) begin
            bank_r[port_sel].raw <= io_req.data;    // Whole byte, all bits kept
        end
    end

    assign bank_set = bank_r;

    ////////////////////////////////////////
    // Readback
    ////////////////////////////////////////

    logic rd_hit;

    assign rd_hit = io_req.rd_active && port_hit;

    // Output enable for the board data pin
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            d_oe <= 1'b0;
        end else begin
            d_oe <= rd_hit;                 // Drops one cycle after rd_active
        end
    end

    // Data only matters while d_oe is high
    always_ff @(posedge sysclk) begin
        if (rd_hit) begin
            d_out <= bank_r[port_sel].raw;
        end
    end

endmodule

//--- source/mem_mapper.sv
`timescale 1ns/1ps

module mem_mapper
    import z80_bus_pkg::*;
    import memmap_pkg::*;
(
    input  z80_bus_s  bus,
    input  bank_set_t bank_set,
    output mem_sel_s  mem_sel
);

    ////////////////////////////////////////
    // Quarter lookup
    ////////////////////////////////////////

    logic [1:0] quarter;
    bank_reg_u  bank_cur;                   // Register for this quarter

    assign quarter  = bus.addr[15:14];      // 16 KB quarters
    assign bank_cur = bank_set[quarter];

    ////////////////////////////////////////
    // Cycle qualification
    ////////////////////////////////////////

    logic mem_cycle;                        // Read or write, no refresh
    logic wr_blocked;                       // Write to a readonly bank
    logic ce_allow;

    // Refresh has mreq low with both rd and wr high
    assign mem_cycle  = !bus.mreq_n && (!bus.rd_n || !bus.wr_n);
    assign wr_blocked = !bus.wr_n && bank_cur.fields.readonly;
    assign ce_allow   = mem_cycle && !wr_blocked;

    ////////////////////////////////////////
    // Chip enables
    ////////////////////////////////////////

    logic is_rom, is_cart, is_ram;

    // Regions by top page bits, exactly one is set
    assign is_ram  = (bank_cur.fields.page[5] == region_ram);
    assign is_cart = !is_ram && (bank_cur.fields.page[5:4] == region_cart);
    assign is_rom  = !is_ram && (bank_cur.fields.page[5:4] == region_rom);

    always_comb begin
        mem_sel           = '0;
        mem_sel.ba        = bank_cur.fields.page[4:0];  // Driven in every cycle
        mem_sel.rom_ce_n  = 1'b1;                       // Idle high
        mem_sel.cart_ce_n = 1'b1;
        mem_sel.ram_ce_n  = 1'b1;
        if (ce_allow) begin
            mem_sel.rom_ce_n  = !is_rom;
            mem_sel.cart_ce_n = !is_cart;
            mem_sel.ram_ce_n  = !is_ram;
        end
    end

    // Reserved bit not decoded here, only read back

endmodule

//--- source/z80_bus_top.sv
`timescale 1ns/1ps

module z80_bus_top
    import z80_bus_pkg::*;
    import memmap_pkg::*;
#(
    parameter int reset_bits = 22           // Full length on the board
) (
    input  logic       sysclk,
    input  logic       rst_n,               // Board power-on reset
    input  z80_bus_s   bus,                 // Async Z80 pins
    output logic       z80_reset_n,
    output logic       phi,                 // Z80 clock
    output mem_sel_s   mem_sel,
    output logic [7:0] d_out,               // Wrapper builds the tristate
    output logic       d_oe
);

    ////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////

    io_req_s   io_req;                      // Sampler to registers
    bank_set_t bank_set;                    // Registers to mapper

    ////////////////////////////////////////
    // Clock and reset
    ////////////////////////////////////////

    z80_clock_reset #(
        .reset_bits  (reset_bits)
    ) u_clock_reset (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .z80_reset_n (z80_reset_n),
        .phi         (phi)
    );

    ////////////////////////////////////////
    // Bus path
    ////////////////////////////////////////

    z80_bus_sampler u_sampler (
        .sysclk (sysclk),
        .rst_n  (rst_n),
        .bus    (bus),
        .io_req (io_req)
    );

    bank_regs u_bank_regs (
        .sysclk   (sysclk),
        .rst_n    (rst_n),
        .io_req   (io_req),
        .bank_set (bank_set),
        .d_out    (d_out),
        .d_oe     (d_oe)
    );

    // Memory path bypasses the sampler, zero latency
    mem_mapper u_mapper (
        .bus      (bus),
        .bank_set (bank_set),
        .mem_sel  (mem_sel)
    );

endmodule

//--- verif/tb_bus_tasks.svh
////////////////////////////////////////
// Z80 bus cycles
////////////////////////////////////////

// Strobes high, address and data zero
task automatic idle_bus();
    bus <= {16'h0000, 8'h00, 5'b11111};     // rd, wr, mreq, iorq, m1 all inactive
endtask

task automatic write_port(input logic [7:0] port, input logic [7:0] value);
    @(posedge sysclk);
    bus.addr   <= {8'h00, port};            // Upper byte unused by the decode
    bus.data   <= value;
    bus.iorq_n <= 1'b0;
    bus.wr_n   <= 1'b0;
    repeat (hold_cycles) @(posedge sysclk);
    idle_bus();
    repeat (4) @(posedge sysclk);           // Sampler must see the release
endtask

task automatic read_port(input logic [7:0] port, output logic [7:0] value,
                         output logic ok);
    int  waited;
    logic fell;
    ok     = 1'b0;
    fell   = 1'b0;
    value  = 8'h00;
    waited = 0;
    @(posedge sysclk);
    bus.addr   <= {8'h00, port};
    bus.iorq_n <= 1'b0;
    bus.rd_n   <= 1'b0;
    while (!ok && waited < wait_limit) begin
        @(negedge sysclk);                  // Sample away from the drive edge
        waited++;
        if (d_oe) ok = 1'b1;
    end
    if (ok) begin
        value = d_out;
    end else begin
        timeouts++;
        $display("Timeout: d_oe never rose during the I/O read of port %h", port);
    end
    if (waited < hold_cycles) repeat (hold_cycles - waited) @(posedge sysclk);
    @(posedge sysclk);
    idle_bus();
    waited = 0;
    while (!fell && waited < wait_limit) begin
        @(negedge sysclk);
        waited++;
        if (!d_oe) fell = 1'b1;
    end
    if (!fell) begin
        timeouts++;
        $display("Timeout: d_oe stayed high after the I/O read of port %h ended", port);
    end
endtask

// Int ack, rd also pulled low as a worst case
task automatic ack_interrupt(input logic [7:0] port, output logic [7:0] oe_cycles);
    oe_cycles = 8'h00;
    @(posedge sysclk);
    bus.addr   <= {8'h00, port};
    bus.iorq_n <= 1'b0;
    bus.m1_n   <= 1'b0;
    bus.rd_n   <= 1'b0;
    repeat (hold_cycles + 4) begin
        @(negedge sysclk);
        if (d_oe) oe_cycles++;              // Any high cycle is a leak
    end
    @(posedge sysclk);
    idle_bus();
    repeat (4) @(posedge sysclk);
endtask

task automatic access_memory(input logic [15:0] addr, input logic [7:0] value,
                             input logic is_write, output mem_sel_s seen);
    @(posedge sysclk);
    bus.addr   <= addr;
    bus.data   <= value;
    bus.mreq_n <= 1'b0;
    bus.rd_n   <= is_write;
    bus.wr_n   <= !is_write;
    repeat (2) @(negedge sysclk);
    seen = mem_sel;                         // Mapper is combinational
    repeat (hold_cycles - 2) @(posedge sysclk);
    idle_bus();
    @(posedge sysclk);
endtask

////////////////////////////////////////
// Reference model and checks
////////////////////////////////////////

function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Mapping rules: page[5:4] picks the region, readonly blocks writes
function automatic mem_sel_s expected_sel(input bank_set_t banks, input logic [15:0] addr,
                                          input logic is_write);
    bank_reg_u b;
    mem_sel_s  s;
    b    = banks[addr[15:14]];
    s.ba = b.fields.page[4:0];
    {s.rom_ce_n, s.cart_ce_n, s.ram_ce_n} = ce_none;
    if (!(is_write && b.fields.readonly)) begin
        case (b.fields.page[5:4])
            2'b00:   {s.rom_ce_n, s.cart_ce_n, s.ram_ce_n} = ce_rom;
            2'b01:   {s.rom_ce_n, s.cart_ce_n, s.ram_ce_n} = ce_cart;
            default: {s.rom_ce_n, s.cart_ce_n, s.ram_ce_n} = ce_ram;   // Pages 32..63
        endcase
    end
    return s;
endfunction

task automatic check_mem_sel(input mem_sel_s got, input mem_sel_s exp, input string what);
    if (got !== exp) begin
        errors++;
        $display("Fail at %0t: %s, mem_sel ba=%0d ce=%b, expected ba=%0d ce=%b",
                 $time, what, got.ba, {got.rom_ce_n, got.cart_ce_n, got.ram_ce_n},
                 exp.ba, {exp.rom_ce_n, exp.cart_ce_n, exp.ram_ce_n});
    end
endtask

task automatic check_data(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
        errors++;
        $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
endtask

//--- verif/tb_z80_bus_top.sv
`timescale 1ns/1ps

module tb_z80_bus_top
    import z80_bus_pkg::*;
    import memmap_pkg::*;
();

    localparam int hold_cycles = 8;         // Strobe length of every bus cycle
    localparam int wait_limit  = 20;        // Budget for each wait loop
    localparam logic [2:0] ce_rom  = 3'b011;    // {rom, cart, ram} active low
    localparam logic [2:0] ce_cart = 3'b101;
    localparam logic [2:0] ce_ram  = 3'b110;
    localparam logic [2:0] ce_none = 3'b111;

    typedef enum logic [2:0] {op_io_write, op_io_read, op_mem_read, op_mem_write,
                              op_int_ack} op_e;

    typedef struct packed {
        op_e         op;
        logic [15:0] addr;                  // Port in the low byte for I/O rows
        logic [7:0]  data;
        mem_sel_s    exp_sel;               // Memory rows only
        logic [7:0]  exp_data;              // Readback and int ack rows
    } row_t;

    logic       sysclk;
    logic       rst_n;
    z80_bus_s   bus;
    logic       z80_reset_n;
    logic       phi;
    mem_sel_s   mem_sel;
    logic [7:0] d_out;
    logic       d_oe;
    int         errors   = 0;
    int         timeouts = 0;
    bank_set_t  model;                      // Expected bank contents
    logic [31:0] lcg_state;

    `include "tb_bus_tasks.svh"

    z80_bus_top #(.reset_bits(4)) DUT (
        .sysclk (sysclk), .rst_n (rst_n), .bus (bus),
        .z80_reset_n (z80_reset_n), .phi (phi),
        .mem_sel (mem_sel), .d_out (d_out), .d_oe (d_oe)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;       // 50 MHz
    end

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    localparam int num_rows = 31;
    localparam row_t stim_table [num_rows] = '{
        '{op_mem_read,  16'h0100, 8'h00, {5'd0,  ce_rom},  8'h00},  // Reset map
        '{op_mem_read,  16'h4100, 8'h00, {5'd1,  ce_ram},  8'h00},
        '{op_mem_read,  16'h8100, 8'h00, {5'd2,  ce_ram},  8'h00},
        '{op_mem_read,  16'hC100, 8'h00, {5'd19, ce_cart}, 8'h00},
        '{op_mem_write, 16'h0200, 8'h55, {5'd0,  ce_none}, 8'h00},  // Readonly ROM
        '{op_mem_write, 16'hC200, 8'h55, {5'd19, ce_none}, 8'h00},
        '{op_mem_write, 16'h4200, 8'h55, {5'd1,  ce_ram},  8'h00},
        '{op_io_read,   16'h00F0, 8'h00, {5'd0,  ce_none}, 8'h80},
        '{op_io_read,   16'h00F3, 8'h00, {5'd0,  ce_none}, 8'h93},
        '{op_io_write,  16'h00F1, 8'h05, {5'd0,  ce_none}, 8'h00},  // ROM page 5
        '{op_mem_read,  16'h4000, 8'h00, {5'd5,  ce_rom},  8'h00},
        '{op_io_write,  16'h00F2, 8'h1A, {5'd0,  ce_none}, 8'h00},  // Cart page 26
        '{op_mem_read,  16'h8000, 8'h00, {5'd26, ce_cart}, 8'h00},
        '{op_io_write,  16'h00F3, 8'h7F, {5'd0,  ce_none}, 8'h00},  // RAM 63, reserved set
        '{op_mem_read,  16'hFFFF, 8'h00, {5'd31, ce_ram},  8'h00},
        '{op_io_write,  16'h00F0, 8'hA8, {5'd0,  ce_none}, 8'h00},  // RAM 40, readonly
        '{op_mem_read,  16'h0000, 8'h00, {5'd8,  ce_ram},  8'h00},
        '{op_io_write,  16'h00F4, 8'h00, {5'd0,  ce_none}, 8'h00},  // Outside bank range
        '{op_io_write,  16'h0010, 8'h00, {5'd0,  ce_none}, 8'h00},
        '{op_mem_read,  16'h0000, 8'h00, {5'd8,  ce_ram},  8'h00},
        '{op_mem_read,  16'h4000, 8'h00, {5'd5,  ce_rom},  8'h00},
        '{op_io_read,   16'h00F0, 8'h00, {5'd0,  ce_none}, 8'hA8},
        '{op_io_read,   16'h00F1, 8'h00, {5'd0,  ce_none}, 8'h05},
        '{op_io_read,   16'h00F2, 8'h00, {5'd0,  ce_none}, 8'h1A},
        '{op_io_read,   16'h00F3, 8'h00, {5'd0,  ce_none}, 8'h7F},
        '{op_int_ack,   16'h00F0, 8'h00, {5'd0,  ce_none}, 8'h00},  // No readback
        '{op_mem_write, 16'h0123, 8'h3C, {5'd8,  ce_none}, 8'h00},
        '{op_io_write,  16'h00F0, 8'h28, {5'd0,  ce_none}, 8'h00},  // Clear readonly
        '{op_mem_write, 16'h0123, 8'h3C, {5'd8,  ce_ram},  8'h00},
        '{op_io_read,   16'h00F0, 8'h00, {5'd0,  ce_none}, 8'h28},
        '{op_mem_write, 16'h4000, 8'hC3, {5'd5,  ce_rom},  8'h00}   // Flash write allowed
    };

    initial begin
        int         cycles;
        logic       released;
        logic [7:0] toggles;
        logic       changed;
        logic       last_changed;
        logic       prev_phi;
        row_t       row;
        mem_sel_s   got;
        logic [7:0] rd_byte;
        logic       ok;
        logic [7:0] port;
        logic [15:0] addr;

        rst_n <= 1'b0;
        idle_bus();
        model = bank_reset_value;
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        check_data({7'd0, z80_reset_n}, 8'h00, "z80_reset_n during reset");
        check_data({7'd0, phi}, 8'h00, "phi during reset");
        check_data({7'd0, d_oe}, 8'h00, "d_oe during reset");
        check_mem_sel(mem_sel, {5'd0, ce_none}, "idle bus in reset");
        @(posedge sysclk);
        rst_n <= 1'b1;                      // Third edge ends the reset

        // Z80 reset release, 2^4 edges
        cycles   = 0;
        released = 1'b0;
        while (!released && cycles < 40) begin
            @(posedge sysclk);
            cycles++;
            @(negedge sysclk);
            if (z80_reset_n) released = 1'b1;
        end
        if (released) begin
            check_data(8'(cycles), 8'd16, "sysclk edges until z80_reset_n rose");
        end else begin
            timeouts++;
            $display("Timeout: z80_reset_n never went high after reset");
        end
        check_data({7'd0, d_oe}, 8'h00, "d_oe after reset");

        // Phase clock, one change per two edges
        toggles = 8'd0;
        last_changed = 1'b0;
        prev_phi = phi;
        for (int i = 0; i < 32; i++) begin
            @(negedge sysclk);
            changed = (phi != prev_phi);
            if (i > 0) check_data({7'd0, changed}, {7'd0, !last_changed}, "phi toggle pattern");
            if (changed) toggles++;
            last_changed = changed;
            prev_phi     = phi;
            check_data({7'd0, z80_reset_n}, 8'h01, "z80_reset_n stays high");
        end
        check_data(toggles, 8'd16, "phi toggles in 32 cycles");

        for (int i = 0; i < num_rows; i++) begin
            row = stim_table[i];
            case (row.op)
                op_io_write: begin
                    write_port(row.addr[7:0], row.data);
                    if (row.addr[7:0] >= bank_port_base && row.addr[7:0] <= bank_port_base + 8'd3)
                        model[row.addr[1:0]].raw = row.data;
                end
                op_io_read: begin
                    read_port(row.addr[7:0], rd_byte, ok);
                    if (ok) check_data(rd_byte, row.exp_data, $sformatf("row %0d readback", i));
                end
                op_int_ack: begin
                    ack_interrupt(row.addr[7:0], rd_byte);
                    check_data(rd_byte, row.exp_data, $sformatf("row %0d d_oe cycles", i));
                end
                default: begin
                    access_memory(row.addr, row.data, row.op == op_mem_write, got);
                    check_mem_sel(got, row.exp_sel, $sformatf("row %0d at %h", i, row.addr));
                end
            endcase
        end

        // Random bank writes against the model
        lcg_state = 32'h3a032e70;
        for (int n = 0; n < 20; n++) begin
            lcg_state = lcg_step(lcg_state);
            port = bank_port_base + {6'd0, lcg_state[31:30]};
            write_port(port, lcg_state[23:16]);
            model[port[1:0]].raw = lcg_state[23:16];
            lcg_state = lcg_step(lcg_state);
            addr = {port[1:0], lcg_state[29:16]};   // Same quarter as the bank
            access_memory(addr, lcg_state[7:0], 1'b0, got);
            check_mem_sel(got, expected_sel(model, addr, 1'b0), $sformatf("random read %h", addr));
            access_memory(addr, lcg_state[7:0], 1'b1, got);
            check_mem_sel(got, expected_sel(model, addr, 1'b1), $sformatf("random write %h", addr));
        end

        $display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sim.f
source/z80_bus_pkg.sv
source/memmap_pkg.sv
source/z80_clock_reset.sv
source/z80_bus_sampler.sv
source/bank_regs.sv
source/mem_mapper.sv
source/z80_bus_top.sv
+incdir+verif
verif/tb_z80_bus_top.sv

//--- Makefile
# Verilator build and run for the Z80 bus core

VERILATOR ?= verilator
TOP       ?= tb_z80_bus_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= NO ERRORS

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard source/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
